//--- src/ooo_macros.svh
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// data path width
`define OOO_XLEN      32

// register counts
`define OOO_NUM_ARCH  32
`define OOO_NUM_PHYS  64

// queue depths
`define OOO_ROB_DEPTH 16
`define OOO_RS_DEPTH  8

`endif

//--- src/ooo_pkg.sv
`include "ooo_macros.svh"

package ooo_pkg;

    typedef logic [$clog2(`OOO_NUM_PHYS)-1:0]  phys_tag_t;
    typedef logic [$clog2(`OOO_NUM_ARCH)-1:0]  arch_reg_t;
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] rob_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        arch_reg_t  rs2;
        arch_reg_t  rs1;
        logic [2:0] funct3;
        arch_reg_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        arch_reg_t   rs1;
        logic [2:0]  funct3;
        arch_reg_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // register view or immediate view of the same word
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        alu_op_e              op;
        phys_tag_t            src1_tag;
        phys_tag_t            src2_tag;
        logic                 src1_rdy;
        logic                 src2_rdy;
        logic [`OOO_XLEN-1:0] imm;
        logic                 use_imm;
        phys_tag_t            dst_tag;
        rob_idx_t             rob_idx;
    } dispatch_t;

    typedef struct packed {
        logic                 valid;
        phys_tag_t            tag;
        rob_idx_t             rob_idx;
        logic [`OOO_XLEN-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic                 valid;
        arch_reg_t            rd;
        logic [`OOO_XLEN-1:0] value;
        phys_tag_t            old_tag;
    } retire_t;

endpackage

//--- src/decode_rename.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module decode_rename (
    input  logic               clk,
    input  logic               rst_n,
    input  ooo_pkg::instr_u    instr,
    input  logic               instr_valid,
    output logic               instr_ready,
    output ooo_pkg::phys_tag_t src1_tag,
    output ooo_pkg::phys_tag_t src2_tag,
    input  logic               src1_valid,
    input  logic               src2_valid,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               rs_full,
    input  logic               rob_full,
    input  ooo_pkg::rob_idx_t  rob_tail,
    output ooo_pkg::dispatch_t disp,
    output logic               disp_en,
    output ooo_pkg::phys_tag_t alloc_tag,
    output ooo_pkg::phys_tag_t alloc_old_tag,
    output ooo_pkg::arch_reg_t alloc_rd,
    input  ooo_pkg::retire_t   retire
);
    import ooo_pkg::*;

    localparam int FL_DEPTH = `OOO_NUM_PHYS - `OOO_NUM_ARCH;
    localparam int FL_AW = $clog2(FL_DEPTH);
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    phys_tag_t rat [`OOO_NUM_ARCH];
    phys_tag_t free_list [FL_DEPTH];
    logic [FL_AW-1:0] fl_head;
    logic [FL_AW-1:0] fl_tail;
    logic [FL_AW:0] fl_count;

    alu_op_e op;
    logic supported;
    logic is_imm;
    logic needs_alloc;
    logic res_ok;
    logic push;

    always_comb begin
        op = ALU_ADD;
        supported = 1'b0;
        is_imm = (instr.i.opcode == OPC_OP_IMM);
        if (instr.r.opcode == OPC_OP) begin
            // funct7 bit 5 only for sub and sra
            supported = (instr.r.funct7 == 7'b0000000) ||
                        (instr.r.funct7 == 7'b0100000 &&
                         (instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101));
            case (instr.r.funct3)
                3'b000: op = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
                3'b001: op = ALU_SLL;
                3'b010: op = ALU_SLT;
                3'b011: op = ALU_SLTU;
                3'b100: op = ALU_XOR;
                3'b101: op = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: op = ALU_OR;
                default: op = ALU_AND;
            endcase
        end else if (is_imm) begin
            supported = 1'b1;
            case (instr.i.funct3)
                3'b000: op = ALU_ADD;
                3'b010: op = ALU_SLT;
                3'b011: op = ALU_SLTU;
                3'b100: op = ALU_XOR;
                3'b110: op = ALU_OR;
                3'b111: op = ALU_AND;
                default: supported = 1'b0;  // immediate shifts not kept
            endcase
        end
    end

    assign needs_alloc = supported && (instr.r.rd != '0);  // x0 results go nowhere
    assign res_ok = !rob_full && !rs_full && (fl_count != '0);
    assign instr_ready = res_ok || (instr_valid && !needs_alloc);
    assign disp_en = instr_valid && instr_ready && needs_alloc;
    assign push = retire.valid && (retire.rd != '0);

    assign src1_tag = rat[instr.r.rs1];
    assign src2_tag = rat[instr.r.rs2];
    assign alloc_tag = free_list[fl_head];
    assign alloc_old_tag = rat[instr.r.rd];
    assign alloc_rd = instr.r.rd;

    always_comb begin
        disp.op = op;
        disp.src1_tag = src1_tag;
        disp.src2_tag = src2_tag;
        disp.src1_rdy = src1_valid || (cdb.valid && cdb.tag == src1_tag);
        disp.src2_rdy = is_imm || src2_valid || (cdb.valid && cdb.tag == src2_tag);
        disp.imm = {{(`OOO_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
        disp.use_imm = is_imm;
        disp.dst_tag = alloc_tag;
        disp.rob_idx = rob_tail;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_NUM_ARCH; i++)
                rat[i] <= phys_tag_t'(i);  // identity map
        end else if (disp_en) begin
            rat[instr.r.rd] <= alloc_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < FL_DEPTH; i++)
                free_list[i] <= phys_tag_t'(`OOO_NUM_ARCH + i);
            fl_head <= '0;
            fl_tail <= '0;
            fl_count <= (FL_AW+1)'(FL_DEPTH);
        end else begin
            if (disp_en)
                fl_head <= fl_head + 1'b1;
            if (push) begin
                free_list[fl_tail] <= retire.old_tag;
                fl_tail <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + (FL_AW+1)'(push) - (FL_AW+1)'(disp_en);
        end
    end

endmodule

//--- src/phys_regfile.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module phys_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ooo_pkg::phys_tag_t   lookup1,
    input  ooo_pkg::phys_tag_t   lookup2,
    output logic                 lookup1_valid,
    output logic                 lookup2_valid,
    input  ooo_pkg::phys_tag_t   rd_tag_a,
    input  ooo_pkg::phys_tag_t   rd_tag_b,
    output logic [`OOO_XLEN-1:0] rd_data_a,
    output logic [`OOO_XLEN-1:0] rd_data_b,
    input  ooo_pkg::phys_tag_t   clear_tag,
    input  logic                 clear_en,
    input  ooo_pkg::cdb_t        cdb
);

    logic [`OOO_XLEN-1:0] prf [`OOO_NUM_PHYS];
    logic [`OOO_NUM_PHYS-1:0] prf_valid;

    assign lookup1_valid = prf_valid[lookup1];
    assign lookup2_valid = prf_valid[lookup2];
    assign rd_data_a = prf[rd_tag_a];
    assign rd_data_b = prf[rd_tag_b];

    // low half holds the initial architectural mapping
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prf_valid <= {{(`OOO_NUM_PHYS-`OOO_NUM_ARCH){1'b0}}, {`OOO_NUM_ARCH{1'b1}}};
        end else begin
            if (clear_en)
                prf_valid[clear_tag] <= 1'b0;
            if (cdb.valid)
                prf_valid[cdb.tag] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_NUM_ARCH; i++)
                prf[i] <= '0;
        end else if (cdb.valid) begin
            prf[cdb.tag] <= cdb.value;
        end
    end

endmodule

//--- src/reservation_station.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module reservation_station (
    input  logic               clk,
    input  logic               rst_n,
    input  ooo_pkg::dispatch_t disp,
    input  logic               disp_en,
    output logic               full,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::dispatch_t issue,
    output logic               issue_en,
    output ooo_pkg::phys_tag_t opnd_tag_a,
    output ooo_pkg::phys_tag_t opnd_tag_b
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_RS_DEPTH;
    localparam int IW = $clog2(DEPTH);

    dispatch_t ent [DEPTH];  // index 0 is the oldest
    dispatch_t nxt [DEPTH];
    logic [IW:0] count;
    logic [IW:0] count_kept;
    logic [IW-1:0] sel;

    // scan down so the lowest ready index wins
    always_comb begin
        issue_en = 1'b0;
        sel = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (i < int'(count) && ent[i].src1_rdy && ent[i].src2_rdy) begin
                issue_en = 1'b1;
                sel = IW'(i);
            end
        end
    end

    assign issue = ent[sel];
    assign opnd_tag_a = issue.src1_tag;
    assign opnd_tag_b = issue.src2_tag;
    assign full = (count == (IW+1)'(DEPTH));
    assign count_kept = count - (IW+1)'(issue_en);

    always_comb begin
        for (int i = 0; i < DEPTH - 1; i++)
            nxt[i] = (issue_en && i >= int'(sel)) ? ent[i + 1] : ent[i];  // close the gap
        nxt[DEPTH - 1] = ent[DEPTH - 1];
        for (int i = 0; i < DEPTH; i++) begin
            if (cdb.valid && nxt[i].src1_tag == cdb.tag)
                nxt[i].src1_rdy = 1'b1;
            if (cdb.valid && nxt[i].src2_tag == cdb.tag)
                nxt[i].src2_rdy = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            count <= '0;
        else
            count <= count_kept + (IW+1)'(disp_en);
    end

    // new entry lands just behind the survivors
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++)
            ent[i] <= (disp_en && i == int'(count_kept)) ? disp : nxt[i];
    end

endmodule

//--- src/alu_unit.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module alu_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ooo_pkg::dispatch_t   issue,
    input  logic                 issue_en,
    input  logic [`OOO_XLEN-1:0] opnd_a,
    input  logic [`OOO_XLEN-1:0] opnd_b,
    output ooo_pkg::cdb_t        cdb
);
    import ooo_pkg::*;

    logic [`OOO_XLEN-1:0] b;
    logic [`OOO_XLEN-1:0] result;
    logic [4:0] shamt;

    assign b = issue.use_imm ? issue.imm : opnd_b;
    assign shamt = b[4:0];

    always_comb begin
        case (issue.op)
            ALU_SUB:  result = opnd_a - b;
            ALU_AND:  result = opnd_a & b;
            ALU_OR:   result = opnd_a | b;
            ALU_XOR:  result = opnd_a ^ b;
            ALU_SLT:  result = {{(`OOO_XLEN-1){1'b0}}, $signed(opnd_a) < $signed(b)};
            ALU_SLTU: result = {{(`OOO_XLEN-1){1'b0}}, opnd_a < b};
            ALU_SLL:  result = opnd_a << shamt;
            ALU_SRL:  result = opnd_a >> shamt;
            ALU_SRA:  result = $signed(opnd_a) >>> shamt;
            default:  result = opnd_a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            cdb.valid <= 1'b0;
        else
            cdb.valid <= issue_en;
        cdb.tag <= issue.dst_tag;
        cdb.rob_idx <= issue.rob_idx;
        cdb.value <= result;
    end

endmodule

//--- src/reorder_buffer.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module reorder_buffer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               alloc_en,
    input  ooo_pkg::arch_reg_t alloc_rd,
    input  ooo_pkg::phys_tag_t alloc_tag,
    input  ooo_pkg::phys_tag_t alloc_old_tag,
    output ooo_pkg::rob_idx_t  tail,
    output logic               full,
    input  ooo_pkg::cdb_t      cdb,
    output ooo_pkg::retire_t   retire,
    output logic               busy
);
    import ooo_pkg::*;

    localparam int DEPTH = `OOO_ROB_DEPTH;
    localparam int CW = $clog2(DEPTH) + 1;

    arch_reg_t rob_rd [DEPTH];
    phys_tag_t rob_tag [DEPTH];
    phys_tag_t rob_old [DEPTH];
    logic [`OOO_XLEN-1:0] rob_val [DEPTH];
    logic [DEPTH-1:0] rob_done;
    rob_idx_t head;
    logic [CW-1:0] count;
    logic complete;

    // broadcast must match the tag the slot was given
    assign complete = cdb.valid && (rob_tag[cdb.rob_idx] == cdb.tag);
    assign full = (count == CW'(DEPTH));
    assign busy = (count != '0);

    always_comb begin
        retire.valid = busy && rob_done[head];
        retire.rd = rob_rd[head];
        retire.value = rob_val[head];
        retire.old_tag = rob_old[head];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            rob_done <= '0;
        end else begin
            if (alloc_en) begin
                rob_done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (complete)
                rob_done[cdb.rob_idx] <= 1'b1;
            if (retire.valid)
                head <= head + 1'b1;  // one per cycle, in order
            count <= count + CW'(alloc_en) - CW'(retire.valid);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            rob_rd[tail] <= alloc_rd;
            rob_tag[tail] <= alloc_tag;
            rob_old[tail] <= alloc_old_tag;
        end
        if (complete)
            rob_val[cdb.rob_idx] <= cdb.value;
    end

endmodule

//--- src/arch_regfile_apb.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module arch_regfile_apb (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ooo_pkg::retire_t     retire,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [`OOO_XLEN-1:0] pwdata,
    output logic [`OOO_XLEN-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr
);

    logic [`OOO_XLEN-1:0] regs [`OOO_NUM_ARCH];
    logic access;
    logic bad;

    assign access = psel && penable;
    assign bad = pwrite || paddr[7];  // read only, 32 words below 128
    assign pready = 1'b1;
    assign pslverr = access && bad;
    assign prdata = (access && !bad) ? regs[paddr[6:2]] : '0;

    // x0 is never written
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_NUM_ARCH; i++)
                regs[i] <= '0;
        end else if (retire.valid && retire.rd != '0) begin
            regs[retire.rd] <= retire.value;
        end
    end

endmodule

//--- src/ooo_core_top.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module ooo_core_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  ooo_pkg::instr_u      instr,
    input  logic                 instr_valid,
    output logic                 instr_ready,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [`OOO_XLEN-1:0] pwdata,
    output logic [`OOO_XLEN-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 busy
);
    import ooo_pkg::*;

    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t alloc_tag;
    phys_tag_t alloc_old_tag;
    phys_tag_t opnd_tag_a;
    phys_tag_t opnd_tag_b;
    arch_reg_t alloc_rd;
    rob_idx_t rob_tail;
    logic src1_valid;
    logic src2_valid;
    logic rs_full;
    logic rob_full;
    logic disp_en;
    logic issue_en;
    dispatch_t disp;
    dispatch_t issue;
    cdb_t cdb;
    retire_t retire;
    logic [`OOO_XLEN-1:0] opnd_a;
    logic [`OOO_XLEN-1:0] opnd_b;

    decode_rename u_decode_rename (
        .clk(clk), .rst_n(rst_n),
        .instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready),
        .src1_tag(src1_tag), .src2_tag(src2_tag),
        .src1_valid(src1_valid), .src2_valid(src2_valid),
        .cdb(cdb), .rs_full(rs_full), .rob_full(rob_full), .rob_tail(rob_tail),
        .disp(disp), .disp_en(disp_en),
        .alloc_tag(alloc_tag), .alloc_old_tag(alloc_old_tag), .alloc_rd(alloc_rd),
        .retire(retire)
    );

    phys_regfile u_phys_regfile (
        .clk(clk), .rst_n(rst_n),
        .lookup1(src1_tag), .lookup2(src2_tag),
        .lookup1_valid(src1_valid), .lookup2_valid(src2_valid),
        .rd_tag_a(opnd_tag_a), .rd_tag_b(opnd_tag_b),
        .rd_data_a(opnd_a), .rd_data_b(opnd_b),
        .clear_tag(alloc_tag), .clear_en(disp_en),  // new tag goes pending
        .cdb(cdb)
    );

    reservation_station u_reservation_station (
        .clk(clk), .rst_n(rst_n),
        .disp(disp), .disp_en(disp_en), .full(rs_full), .cdb(cdb),
        .issue(issue), .issue_en(issue_en),
        .opnd_tag_a(opnd_tag_a), .opnd_tag_b(opnd_tag_b)
    );

    alu_unit u_alu_unit (
        .clk(clk), .rst_n(rst_n),
        .issue(issue), .issue_en(issue_en),
        .opnd_a(opnd_a), .opnd_b(opnd_b), .cdb(cdb)
    );

    reorder_buffer u_reorder_buffer (
        .clk(clk), .rst_n(rst_n),
        .alloc_en(disp_en), .alloc_rd(alloc_rd),
        .alloc_tag(alloc_tag), .alloc_old_tag(alloc_old_tag),
        .tail(rob_tail), .full(rob_full), .cdb(cdb),
        .retire(retire), .busy(busy)
    );

    arch_regfile_apb u_arch_regfile_apb (
        .clk(clk), .rst_n(rst_n), .retire(retire),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr)
    );

endmodule

//--- testbench/ooo_core_asserts.sv
`timescale 1ns/100ps

module ooo_core_asserts (
    input logic               clk,
    input logic               rst_n,
    input logic               instr_valid,
    input logic               instr_ready,
    input logic               busy,
    input logic               rob_full,
    input logic               disp_en,
    input ooo_pkg::phys_tag_t alloc_tag,
    input ooo_pkg::cdb_t      cdb
);

    logic realloc;

    assign realloc = disp_en && (alloc_tag == cdb.tag);  // tag handed out again

    idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !busy)
        else $error("busy high in the cycle after reset release");

    // only a dropped word may pass while the ROB is full
    full_blocks_alloc: assert property (@(posedge clk) disable iff (!rst_n)
        rob_full |-> !disp_en && (instr_valid || !instr_ready))
        else $error("allocation or ready while ROB full");

    cdb_tag_once: assert property (@(posedge clk) disable iff (!rst_n)
        (cdb.valid && $past(cdb.valid)) |-> (cdb.tag != $past(cdb.tag)) || $past(realloc))
        else $error("CDB wrote tag %0d twice in a row", cdb.tag);

endmodule

//--- testbench/ooo_core_tb.sv
`timescale 1ns/100ps
`include "ooo_macros.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    typedef struct packed {
        logic [31:0] word;
        logic        drain;  // wait for idle and read back after this word
    } step_t;

    logic clk = 1'b0;
    logic rst_n;
    instr_u instr;
    logic instr_valid;
    logic instr_ready;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic busy;

    logic [31:0] model_regs [`OOO_NUM_ARCH];
    step_t steps [$];
    integer seed = 32'h35e2_969f;
    int errors = 0;
    int wd_cycles = 0;
    logic stall_seen = 1'b0;

    always #5 clk = ~clk;

    ooo_core_top ooo_core_top_i (
        .clk(clk), .rst_n(rst_n),
        .instr(instr), .instr_valid(instr_valid), .instr_ready(instr_ready),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .pready(pready), .pslverr(pslverr), .busy(busy)
    );

    bind ooo_core_top ooo_core_asserts u_core_asserts (
        .clk(clk), .rst_n(rst_n),
        .instr_valid(instr_valid), .instr_ready(instr_ready),
        .busy(busy), .rob_full(rob_full), .disp_en(disp_en),
        .alloc_tag(alloc_tag), .cdb(cdb)
    );

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "run stopped at first error");
        end
    endtask

    function automatic logic [31:0] r_word(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {imm, 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    // in-order ISA model of the kept subset
    task automatic model_exec(input logic [31:0] word);
        logic [6:0] opc;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic ok;
        opc = word[6:0];
        f7 = word[31:25];
        f3 = word[14:12];
        a = model_regs[word[19:15]];
        ok = 1'b0;
        b = 32'd0;
        res = 32'd0;
        if (opc == 7'b0110011) begin
            ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            b = model_regs[word[24:20]];
        end else if (opc == 7'b0010011) begin
            ok = (f3 != 3'd1) && (f3 != 3'd5);  // no immediate shifts
            b = {{20{word[31]}}, word[31:20]};
        end
        case (f3)
            3'd0: res = (opc == 7'b0110011 && f7[5]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: res = (a < b) ? 32'd1 : 32'd0;
            3'd4: res = a ^ b;
            3'd5: begin
                if (f7[5])
                    res = $signed(a) >>> b[4:0];
                else
                    res = a >> b[4:0];
            end
            3'd6: res = a | b;
            default: res = a & b;
        endcase
        if (ok && word[11:7] != 5'd0)
            model_regs[word[11:7]] = res;
    endtask

    task automatic add_step(input logic [31:0] word, input logic drain);
        steps.push_back('{word: word, drain: drain});
    endtask

    task automatic build_program();
        int rd;
        int rs1;
        logic [2:0] f3;
        logic [6:0] f7;
        // independent immediates
        add_step(i_word(12'($random(seed)), 0, 3'd0, 1), 1'b0);
        add_step(i_word(12'($random(seed)), 0, 3'd4, 2), 1'b0);
        add_step(i_word(12'($random(seed)), 0, 3'd2, 3), 1'b0);
        add_step(i_word(12'($random(seed)), 0, 3'd3, 4), 1'b1);
        // every R-type op on a negative and a positive source
        add_step(i_word(12'hffb, 0, 3'd0, 5), 1'b0);
        add_step(i_word(12'h003, 0, 3'd0, 6), 1'b0);
        for (int k = 0; k < 8; k++)
            add_step(r_word(7'h00, 6, 5, 3'(k), 7 + k), 1'b0);
        add_step(r_word(7'h20, 6, 5, 3'd0, 15), 1'b0);  // sub
        add_step(r_word(7'h20, 6, 5, 3'd5, 16), 1'b0);  // sra
        add_step(i_word(12'd35, 0, 3'd0, 17), 1'b0);    // shift by low 5 bits only
        add_step(r_word(7'h00, 17, 6, 3'd1, 18), 1'b0);
        add_step(r_word(7'h20, 17, 5, 3'd5, 19), 1'b0);
        add_step(r_word(7'h00, 7, 7, 3'd0, 7), 1'b0);   // waw on x7
        add_step(r_word(7'h20, 6, 7, 3'd0, 7), 1'b0);
        add_step(r_word(7'h00, 8, 7, 3'd0, 20), 1'b0);
        add_step(i_word(12'($random(seed)), 20, 3'd7, 21), 1'b0);
        add_step(i_word(12'($random(seed)), 21, 3'd6, 22), 1'b1);
        // dependent chain of 40, fills the RS and recycles tags
        for (int k = 0; k < 40; k++) begin
            rd = 1 + k % 24;
            rs1 = 1 + (k + 23) % 24;
            f3 = 3'(k);
            f7 = ((f3 == 3'd0 || f3 == 3'd5) && k[1]) ? 7'h20 : 7'h00;
            if (k % 3 == 0)
                add_step(r_word(f7, 5, rs1, f3, rd), k == 39);
            else
                add_step(i_word(12'($random(seed)), rs1, 3'd0, rd), k == 39);
        end
        // x0 targets and dropped words
        add_step(i_word(12'h005, 1, 3'd0, 0), 1'b0);
        add_step(r_word(7'h00, 2, 1, 3'd0, 0), 1'b0);
        add_step(32'h0000_2483, 1'b0);                   // load
        add_step(i_word(12'h003, 1, 3'd1, 10), 1'b0);    // slli
        add_step(r_word(7'h01, 2, 1, 3'd0, 11), 1'b0);   // mul
        add_step(r_word(7'h00, 1, 0, 3'd0, 23), 1'b1);
    endtask

    // hold the word until the DUT takes it
    task automatic issue_word(input logic [31:0] word);
        logic taken;
        taken = 1'b0;
        instr = word;
        instr_valid = 1'b1;
        while (!taken) begin
            #1;
            taken = instr_ready;
            if (!taken)
                stall_seen = 1'b1;
            @(negedge clk);
        end
        model_exec(word);
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        rdata = prdata;
        err = pslverr;
        compare_value("pready", 32'(pready), 32'd1);
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic read_all();
        logic [31:0] data;
        logic err;
        for (int i = 0; i < `OOO_NUM_ARCH; i++) begin
            apb_access(1'b0, 8'(i * 4), 32'd0, data, err);
            compare_value($sformatf("x%0d", i), data, model_regs[i]);
            compare_value("pslverr", 32'(err), 32'd0);
        end
    endtask

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout after %0d cycles, DUT never went idle", wd_cycles);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0] data;
        logic err;
        int drains;
        rst_n = 1'b0;
        instr = '0;
        instr_valid = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 8'd0;
        pwdata = 32'd0;
        for (int i = 0; i < `OOO_NUM_ARCH; i++)
            model_regs[i] = 32'd0;
        build_program();
        drains = 0;
        foreach (steps[n])
            drains += int'(steps[n].drain);
        wd_cycles = 20 + steps.size() * 40 + (drains + 2) * (`OOO_NUM_ARCH * 2 + 4) + 8;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("instr_ready", 32'(instr_ready), 32'd1);
        compare_value("busy", 32'(busy), 32'd0);
        read_all();

        foreach (steps[n]) begin
            issue_word(steps[n].word);
            if (steps[n].drain) begin
                instr_valid = 1'b0;
                while (busy)
                    @(negedge clk);
                read_all();
            end
        end
        compare_value("instr_ready low seen", 32'(stall_seen), 32'd1);

        apb_access(1'b1, 8'h0c, 32'hdead_beef, data, err);
        compare_value("pslverr", 32'(err), 32'd1);
        apb_access(1'b0, 8'h80, 32'd0, data, err);  // one past the last register
        compare_value("pslverr", 32'(err), 32'd1);
        read_all();

        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+src
src/ooo_pkg.sv
src/decode_rename.sv
src/phys_regfile.sv
src/reservation_station.sv
src/alu_unit.sv
src/reorder_buffer.sv
src/arch_regfile_apb.sv
src/ooo_core_top.sv
testbench/ooo_core_asserts.sv
testbench/ooo_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module ooo_core_tb -Mdir build -o ooo_core_sim

./build/ooo_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
